// File: sim.f
logic/decodeExecPkg.sv
logic/mainDecoder.sv
logic/regFile.sv
logic/idEx.sv
logic/divSequencer.sv
logic/execUnit.sv
logic/decodeExecTop.sv
verification/decodeExec_sva.sv
verification/tbDecodeExec.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbDecodeExec -f sim.f -o simDecodeExec

./obj_dir/simDecodeExec > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
grep -q "Regression passed" sim.log

// File: verification/tbDecodeExec.sv
`timescale 1ns/10ps
`default_nettype none

module tbDecodeExec;

    localparam int DriveDelay = 1;
    localparam int NumDivides = 4;
    localparam int NumOthers  = 110;
    // about 40 cycles per divide and 4 per other instruction, doubled, plus reset
    localparam int TimeoutCycles = 2 * (40 * NumDivides + 4 * NumOthers) + 20;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic        instrValid;
    logic        flush;
    logic        stall;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    // reference model and pending write-backs in program order
    logic [31:0] refRegs [32];
    logic [31:0] refHi;
    logic [31:0] refLo;
    logic [4:0]  expRegQ [$];
    logic [31:0] expDataQ [$];
    int          heldCycles;
    int          cycleCount = 0;

    decodeExecTop u_dut (
        .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid), .flush(flush),
        .stall(stall), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun();
        $display("Regression failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            failRun();
        end
    endtask

    function automatic logic [31:0] rWord(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sa);
        decodeExecPkg::instrWord w;
        w.r.op    = decodeExecPkg::OpSpecial;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.rd    = rd;
        w.r.sa    = sa;
        w.r.funct = funct;
        return w;
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        decodeExecPkg::instrWord w;
        w.i.op  = op;
        w.i.rs  = rs;
        w.i.rt  = rt;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic logic [4:0] pick();
        return 5'($urandom_range(1, 13));
    endfunction

    // model write, r0 never changes and never shows a write-back
    task automatic recordWrite(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            refRegs[rd] = value;
            expRegQ.push_back(rd);
            expDataQ.push_back(value);
        end
    endtask

    // holds the word while stall is high, returns just after the capture edge
    task automatic present(input logic [31:0] word);
        instr      = word;
        instrValid = 1'b1;
        heldCycles = 0;
        @(negedge clk);
        while (stall) begin
            heldCycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #DriveDelay;
    endtask

    // flush on the capture edge turns the decoding word into a bubble
    task automatic discard(input logic [31:0] word);
        instr      = word;
        instrValid = 1'b1;
        flush      = 1'b1;
        @(posedge clk);
        #DriveDelay;
        flush = 1'b0;
    endtask

    task automatic idle(input int cycles);
        instrValid = 1'b0;
        instr      = 32'd0;
        repeat (cycles) begin
            @(posedge clk);
            #DriveDelay;
        end
    endtask

    task automatic drain();
        idle(3);
        checkEq("pending write-backs", expRegQ.size(), 32'd0);
    endtask

    task automatic regOp(input logic [5:0] funct, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [4:0] rd, input logic [4:0] sa);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = refRegs[rs];
        b = refRegs[rt];
        case (funct)
            decodeExecPkg::FnAddu: res = a + b;
            decodeExecPkg::FnSubu: res = a - b;
            decodeExecPkg::FnAnd:  res = a & b;
            decodeExecPkg::FnOr:   res = a | b;
            decodeExecPkg::FnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            decodeExecPkg::FnSll:  res = b << sa;
            decodeExecPkg::FnMfhi: res = refHi;
            decodeExecPkg::FnMflo: res = refLo;
            default:               res = 32'd0;
        endcase
        recordWrite(rd, res);
        present(rWord(funct, rs, rt, rd, sa));
    endtask

    task automatic immOp(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [15:0] imm);
        logic [31:0] res;
        case (op)
            decodeExecPkg::OpAddiu: res = refRegs[rs] + {{16{imm[15]}}, imm};
            decodeExecPkg::OpOri:   res = refRegs[rs] | {16'd0, imm};
            default:                res = {imm, 16'd0};
        endcase
        recordWrite(rt, res);
        present(iWord(op, rs, rt, imm));
    endtask

    task automatic divOp(input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] n;
        logic [31:0] d;
        n = refRegs[rs];
        d = refRegs[rt];
        if (d == 32'd0) begin
            refLo = 32'hffff_ffff;
            refHi = n;
        end else begin
            refLo = n / d;
            refHi = n % d;
        end
        present(rWord(decodeExecPkg::FnDivu, rs, rt, 5'd0, 5'd0));
    endtask

    task automatic loadReg(input logic [4:0] r, input logic [31:0] value);
        immOp(decodeExecPkg::OpLui, 5'd0, r, value[31:16]);
        immOp(decodeExecPkg::OpOri, r, r, value[15:0]);
    endtask

    task automatic immediateTest();
        for (int r = 1; r <= 13; r++) begin
            loadReg(5'(r), $urandom());
        end
        // negative immediates
        immOp(decodeExecPkg::OpAddiu, 5'd1, 5'd14, 16'hfff0 | 16'($urandom_range(0, 15)));
        immOp(decodeExecPkg::OpAddiu, 5'd2, 5'd15, 16'h8000);
        immOp(decodeExecPkg::OpOri, 5'd3, 5'd16, 16'($urandom()));
        immOp(decodeExecPkg::OpLui, 5'd0, 5'd17, 16'hbeef);
        drain();
    endtask

    task automatic aluOpsTest();
        repeat (3) begin
            regOp(decodeExecPkg::FnAddu, pick(), pick(), 5'd14, 5'd0);
            regOp(decodeExecPkg::FnSubu, pick(), pick(), 5'd15, 5'd0);
            regOp(decodeExecPkg::FnAnd, pick(), pick(), 5'd16, 5'd0);
            regOp(decodeExecPkg::FnOr, pick(), pick(), 5'd17, 5'd0);
            regOp(decodeExecPkg::FnSlt, pick(), pick(), 5'd18, 5'd0);
            regOp(decodeExecPkg::FnSll, 5'd0, pick(), 5'd19, 5'($urandom()));
        end
        // signed compare, negative against positive in both orders
        loadReg(5'd20, 32'hffff_fff0);
        loadReg(5'd21, 32'd5);
        regOp(decodeExecPkg::FnSlt, 5'd20, 5'd21, 5'd22, 5'd0);
        regOp(decodeExecPkg::FnSlt, 5'd21, 5'd20, 5'd23, 5'd0);
        drain();
    endtask

    // each instruction reads the previous destination on the next cycle
    task automatic chainTest();
        regOp(decodeExecPkg::FnAddu, 5'd1, 5'd2, 5'd24, 5'd0);
        regOp(decodeExecPkg::FnSubu, 5'd24, 5'd3, 5'd25, 5'd0);
        regOp(decodeExecPkg::FnOr, 5'd25, 5'd24, 5'd26, 5'd0);
        regOp(decodeExecPkg::FnSll, 5'd0, 5'd26, 5'd27, 5'd3);
        immOp(decodeExecPkg::OpAddiu, 5'd27, 5'd28, 16'hff01);
        regOp(decodeExecPkg::FnSlt, 5'd28, 5'd27, 5'd29, 5'd0);
        // r0 destinations
        regOp(decodeExecPkg::FnAddu, 5'd29, 5'd28, 5'd0, 5'd0);
        immOp(decodeExecPkg::OpOri, 5'd0, 5'd0, 16'h1234);
        regOp(decodeExecPkg::FnOr, 5'd29, 5'd0, 5'd30, 5'd0);
        drain();
    endtask

    task automatic divideTest();
        for (int k = 0; k < NumDivides; k++) begin
            loadReg(5'd1, $urandom());
            loadReg(5'd2, $urandom() >> $urandom_range(0, 28));
            // last divide uses r0 as a zero divisor
            divOp(5'd1, (k == NumDivides - 1) ? 5'd0 : 5'd2);
            regOp(decodeExecPkg::FnMfhi, 5'd0, 5'd0, 5'd3, 5'd0);
            checkEq("stall cycles", heldCycles, decodeExecPkg::DivCycles + 1);
            regOp(decodeExecPkg::FnMflo, 5'd0, 5'd0, 5'd4, 5'd0);
        end
        drain();
    endtask

    task automatic flushTest();
        regOp(decodeExecPkg::FnAddu, 5'd5, 5'd6, 5'd20, 5'd0);
        discard(rWord(decodeExecPkg::FnOr, 5'd7, 5'd8, 5'd20, 5'd0));
        regOp(decodeExecPkg::FnOr, 5'd20, 5'd0, 5'd21, 5'd0);
        idle(5);
        discard(iWord(decodeExecPkg::OpLui, 5'd0, 5'd22, 16'h5a5a));
        regOp(decodeExecPkg::FnOr, 5'd22, 5'd0, 5'd23, 5'd0);
        drain();
    endtask

    // write-back monitor, outputs are settled by the falling edge
    always @(negedge clk) begin
        logic [4:0]  expReg;
        logic [31:0] expData;
        if (rstN && wbEn) begin
            if (expRegQ.size() == 0) begin
                $display("Error at %0t: write-back to r%0d with none expected", $time, wbReg);
                failRun();
            end else begin
                expReg  = expRegQ.pop_front();
                expData = expDataQ.pop_front();
                checkEq("wbReg", {27'd0, wbReg}, {27'd0, expReg});
                checkEq("wbData", wbData, expData);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            failRun();
        end
    end

    initial begin
        void'($urandom(32'h813d));
        rstN       = 1'b0;
        instr      = 32'd0;
        instrValid = 1'b0;
        flush      = 1'b0;
        heldCycles = 0;
        refHi      = 32'd0;
        refLo      = 32'd0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'd0;
        end
        repeat (10) @(posedge clk);
        #DriveDelay;
        rstN = 1'b1;
        immediateTest();
        aluOpsTest();
        chainTest();
        divideTest();
        flushTest();
        if (expRegQ.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Error at %0t: %0d write-backs never appeared", $time, expRegQ.size());
            failRun();
        end
    end

endmodule

`default_nettype wire

// File: verification/decodeExec_sva.sv
`timescale 1ns/10ps
`default_nettype none

module decodeExecSva (
    input wire       clk,
    input wire       rstN,
    input wire       stall,
    input wire       wbEn,
    input wire [4:0] wbReg
);

    // length of the current stall run
    int stallRun;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stallRun <= 0;
        end else if (stall) begin
            stallRun <= stallRun + 1;
        end else begin
            stallRun <= 0;
        end
    end

    quietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !wbEn && !stall)
        else $error("wbEn or stall high in the first cycle after reset");

    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        wbEn |-> wbReg != 5'd0)
        else $error("write-back enabled for register 0");

    divideStallLength: assert property (@(posedge clk) disable iff (!rstN)
        $fell(stall) |-> stallRun == decodeExecPkg::DivCycles + 1)
        else $error("stall run length differs from the divide length");

endmodule

bind decodeExecTop decodeExecSva uDecodeExecSva (
    .clk(clk), .rstN(rstN), .stall(stall), .wbEn(wbEn), .wbReg(wbReg)
);

`default_nettype wire

// File: logic/decodeExecTop.sv
`timescale 1ns/10ps
`default_nettype none

module decodeExecTop (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] instr,
    input  wire         instrValid,
    input  wire         flush,
    output logic        stall,
    output logic        wbEn,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData
);

    // decode stage
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [4:0]  destRegD;
    logic [4:0]  saD;
    logic [31:0] immD;
    logic [31:0] rd1D;
    logic [31:0] rd2D;
    logic [decodeExecPkg::AluOpWidth-1:0] aluOpD;
    logic        aluImmSelD;
    logic        regWriteEnD;
    logic [1:0]  hiloSelD;
    logic        divStartD;

    // execute stage
    logic [31:0] rd1E;
    logic [31:0] rd2E;
    logic [31:0] immE;
    logic [4:0]  saE;
    logic [4:0]  destRegE;
    logic [decodeExecPkg::AluOpWidth-1:0] aluOpE;
    logic        aluImmSelE;
    logic        regWriteEE;
    logic [1:0]  hiloSelE;
    logic        divStartE;
    logic        divLoad;
    logic        divStep;
    logic        divWrite;

    mainDecoder uMainDecoder (
        .instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr), .destReg(destRegD), .sa(saD),
        .immExt(immD), .aluOp(aluOpD), .aluImmSel(aluImmSelD), .regWriteEn(regWriteEnD),
        .hiloSel(hiloSelD), .divStart(divStartD)
    );

    // write port is fed straight from the execute write-back
    regFile uRegFile (
        .clk(clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr), .writeEn(wbEn),
        .writeAddr(wbReg), .writeData(wbData), .rd1(rd1D), .rd2(rd2D)
    );

    idEx uIdEx (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush), .instrValid(instrValid),
        .rd1D(rd1D), .rd2D(rd2D), .immD(immD), .saD(saD), .destRegD(destRegD),
        .aluOpD(aluOpD), .aluImmSelD(aluImmSelD), .regWriteEnD(regWriteEnD),
        .hiloSelD(hiloSelD), .divStartD(divStartD), .rd1E(rd1E), .rd2E(rd2E), .immE(immE),
        .saE(saE), .destRegE(destRegE), .aluOpE(aluOpE), .aluImmSelE(aluImmSelE),
        .regWriteEE(regWriteEE), .hiloSelE(hiloSelE), .divStartE(divStartE)
    );

    divSequencer uDivSequencer (
        .clk(clk), .rstN(rstN), .divStartE(divStartE), .divLoad(divLoad),
        .divStep(divStep), .divWrite(divWrite), .stall(stall)
    );

    execUnit uExecUnit (
        .clk(clk), .rstN(rstN), .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .saE(saE),
        .destRegE(destRegE), .aluOpE(aluOpE), .aluImmSelE(aluImmSelE),
        .regWriteEE(regWriteEE), .hiloSelE(hiloSelE), .divLoad(divLoad),
        .divStep(divStep), .divWrite(divWrite), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
    );

endmodule

`default_nettype wire

// File: logic/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit (
    input  wire                                      clk,
    input  wire                                      rstN,
    input  wire  [31:0]                              rd1E,
    input  wire  [31:0]                              rd2E,
    input  wire  [31:0]                              immE,
    input  wire  [4:0]                               saE,
    input  wire  [4:0]                               destRegE,
    input  wire  [decodeExecPkg::AluOpWidth-1:0]     aluOpE,
    input  wire                                      aluImmSelE,
    input  wire                                      regWriteEE,
    input  wire  [1:0]                               hiloSelE,
    input  wire                                      divLoad,
    input  wire                                      divStep,
    input  wire                                      divWrite,
    output logic                                     wbEn,
    output logic [4:0]                               wbReg,
    output logic [31:0]                              wbData
);

    logic [31:0] opB;
    logic [31:0] aluResult;
    logic [31:0] hiReg;
    logic [31:0] loReg;
    logic [31:0] remReg;
    logic [31:0] divisorReg;
    logic [decodeExecPkg::DivCycles-1:0] quoReg;
    logic [32:0] remShift;
    logic [32:0] remDiff;

    assign opB = aluImmSelE ? immE : rd2E;

    always_comb begin
        case (aluOpE)
            decodeExecPkg::AluAdd: aluResult = rd1E + opB;
            decodeExecPkg::AluSub: aluResult = rd1E - opB;
            decodeExecPkg::AluAnd: aluResult = rd1E & opB;
            decodeExecPkg::AluOr:  aluResult = rd1E | opB;
            decodeExecPkg::AluSlt: aluResult = {31'd0, $signed(rd1E) < $signed(opB)};
            decodeExecPkg::AluSll: aluResult = rd2E << saE;
            // immediate already sits in the upper half
            decodeExecPkg::AluLui: aluResult = immE;
            default:               aluResult = 32'd0;
        endcase
    end

    // restoring step: bring in next dividend bit, subtract if it fits
    assign remShift = {remReg, quoReg[decodeExecPkg::DivCycles-1]};
    assign remDiff  = remShift - {1'b0, divisorReg};

    always_ff @(posedge clk) begin
        if (divLoad) begin
            remReg     <= 32'd0;
            quoReg     <= rd1E;
            divisorReg <= rd2E;
        end else if (divStep) begin
            // zero divisor never borrows, giving all-ones quotient
            if (!remDiff[32]) begin
                remReg <= remDiff[31:0];
                quoReg <= {quoReg[decodeExecPkg::DivCycles-2:0], 1'b1};
            end else begin
                remReg <= remShift[31:0];
                quoReg <= {quoReg[decodeExecPkg::DivCycles-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiReg <= 32'd0;
            loReg <= 32'd0;
        end else if (divWrite) begin
            hiReg <= remReg;
            loReg <= quoReg;
        end
    end

    assign wbEn   = regWriteEE & (destRegE != 5'd0);
    assign wbReg  = destRegE;
    assign wbData = (hiloSelE == decodeExecPkg::HiloHi) ? hiReg :
                    (hiloSelE == decodeExecPkg::HiloLo) ? loReg : aluResult;

endmodule

`default_nettype wire

// File: logic/divSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module divSequencer (
    input  wire  clk,
    input  wire  rstN,
    input  wire  divStartE,
    output logic divLoad,
    output logic divStep,
    output logic divWrite,
    output logic stall
);

    // idle when neither running nor finishing
    logic running;
    logic finishing;
    logic idle;
    logic [$clog2(decodeExecPkg::DivCycles)-1:0] stepCnt;

    assign idle = ~running & ~finishing;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running   <= 1'b0;
            finishing <= 1'b0;
            stepCnt   <= '0;
        end else begin
            finishing <= 1'b0;
            if (running) begin
                if (stepCnt == '0) begin
                    running   <= 1'b0;
                    finishing <= 1'b1;
                end else begin
                    stepCnt <= stepCnt - 1'b1;
                end
            end else if (idle && divStartE) begin
                // count down so run lasts exactly DivCycles
                running <= 1'b1;
                stepCnt <= $bits(stepCnt)'(decodeExecPkg::DivCycles - 1);
            end
        end
    end

    assign divLoad  = idle & divStartE;
    assign divStep  = running;
    assign divWrite = finishing;
    // held through load and run, released in finish
    assign stall    = divLoad | running;

endmodule

`default_nettype wire

// File: logic/idEx.sv
`timescale 1ns/10ps
`default_nettype none

module idEx (
    input  wire                                      clk,
    input  wire                                      rstN,
    input  wire                                      stall,
    input  wire                                      flush,
    input  wire                                      instrValid,
    input  wire  [31:0]                              rd1D,
    input  wire  [31:0]                              rd2D,
    input  wire  [31:0]                              immD,
    input  wire  [4:0]                               saD,
    input  wire  [4:0]                               destRegD,
    input  wire  [decodeExecPkg::AluOpWidth-1:0]     aluOpD,
    input  wire                                      aluImmSelD,
    input  wire                                      regWriteEnD,
    input  wire  [1:0]                               hiloSelD,
    input  wire                                      divStartD,
    output logic [31:0]                              rd1E,
    output logic [31:0]                              rd2E,
    output logic [31:0]                              immE,
    output logic [4:0]                               saE,
    output logic [4:0]                               destRegE,
    output logic [decodeExecPkg::AluOpWidth-1:0]     aluOpE,
    output logic                                     aluImmSelE,
    output logic                                     regWriteEE,
    output logic [1:0]                               hiloSelE,
    output logic                                     divStartE
);

    // flush has priority over stall
    // no valid word while not stalled gives a bubble
    logic loadBubble;

    assign loadBubble = flush | (~instrValid & ~stall);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {rd1E, rd2E, immE, saE, destRegE} <= '0;
            {aluOpE, aluImmSelE, regWriteEE, hiloSelE, divStartE} <= '0;
        end else if (loadBubble) begin
            {rd1E, rd2E, immE, saE, destRegE} <= '0;
            {aluOpE, aluImmSelE, regWriteEE, hiloSelE, divStartE} <= '0;
        end else if (!stall) begin
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            immE       <= immD;
            saE        <= saD;
            destRegE   <= destRegD;
            aluOpE     <= aluOpD;
            aluImmSelE <= aluImmSelD;
            regWriteEE <= regWriteEnD;
            hiloSelE   <= hiloSelD;
            divStartE  <= divStartD;
        end
    end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [4:0]  rsAddr,
    input  wire  [4:0]  rtAddr,
    input  wire         writeEn,
    input  wire  [4:0]  writeAddr,
    input  wire  [31:0] writeData,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-through, decode sees this cycle's write-back
    assign rd1 = (rsAddr == 5'd0) ? 32'd0 :
                 (writeEn && writeAddr == rsAddr) ? writeData : regs[rsAddr];
    assign rd2 = (rtAddr == 5'd0) ? 32'd0 :
                 (writeEn && writeAddr == rtAddr) ? writeData : regs[rtAddr];

endmodule

`default_nettype wire

// File: logic/mainDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module mainDecoder (
    input  wire decodeExecPkg::instrWord             instr,
    output logic [4:0]                               rsAddr,
    output logic [4:0]                               rtAddr,
    output logic [4:0]                               destReg,
    output logic [4:0]                               sa,
    output logic [31:0]                              immExt,
    output logic [decodeExecPkg::AluOpWidth-1:0]     aluOp,
    output logic                                     aluImmSel,
    output logic                                     regWriteEn,
    output logic [1:0]                               hiloSel,
    output logic                                     divStart
);

    always_comb begin
        rsAddr     = instr.r.rs;
        rtAddr     = instr.r.rt;
        destReg    = 5'd0;
        sa         = 5'd0;
        immExt     = 32'd0;
        aluOp      = decodeExecPkg::AluNone;
        aluImmSel  = 1'b0;
        regWriteEn = 1'b0;
        hiloSel    = decodeExecPkg::HiloNone;
        divStart   = 1'b0;

        if (instr.r.op == decodeExecPkg::OpSpecial) begin
            // R-type result goes to rd
            destReg    = instr.r.rd;
            sa         = instr.r.sa;
            regWriteEn = 1'b1;
            case (instr.r.funct)
                decodeExecPkg::FnSll:  aluOp = decodeExecPkg::AluSll;
                decodeExecPkg::FnAddu: aluOp = decodeExecPkg::AluAdd;
                decodeExecPkg::FnSubu: aluOp = decodeExecPkg::AluSub;
                decodeExecPkg::FnAnd:  aluOp = decodeExecPkg::AluAnd;
                decodeExecPkg::FnOr:   aluOp = decodeExecPkg::AluOr;
                decodeExecPkg::FnSlt:  aluOp = decodeExecPkg::AluSlt;
                decodeExecPkg::FnMfhi: hiloSel = decodeExecPkg::HiloHi;
                decodeExecPkg::FnMflo: hiloSel = decodeExecPkg::HiloLo;
                decodeExecPkg::FnDivu: begin
                    // only HI/LO change
                    regWriteEn = 1'b0;
                    divStart   = 1'b1;
                end
                default: regWriteEn = 1'b0;
            endcase
        end else begin
            // I-type result goes to rt
            destReg    = instr.i.rt;
            aluImmSel  = 1'b1;
            regWriteEn = 1'b1;
            case (instr.i.op)
                decodeExecPkg::OpAddiu: begin
                    aluOp  = decodeExecPkg::AluAdd;
                    immExt = {{16{instr.i.imm[15]}}, instr.i.imm};
                end
                decodeExecPkg::OpOri: begin
                    aluOp  = decodeExecPkg::AluOr;
                    immExt = {16'd0, instr.i.imm};
                end
                decodeExecPkg::OpLui: begin
                    aluOp  = decodeExecPkg::AluLui;
                    immExt = {instr.i.imm, 16'd0};
                end
                default: regWriteEn = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/decodeExecPkg.sv
`default_nettype none

package decodeExecPkg;

    // primary opcodes
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpLui     = 6'h0f;

    // SPECIAL funct field
    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnMfhi = 6'h10;
    localparam logic [5:0] FnMflo = 6'h12;
    localparam logic [5:0] FnDivu = 6'h1b;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    // ALU codes, zero is the bubble value
    localparam int AluOpWidth = 4;
    localparam logic [AluOpWidth-1:0] AluNone = 4'h0;
    localparam logic [AluOpWidth-1:0] AluAdd  = 4'h1;
    localparam logic [AluOpWidth-1:0] AluSub  = 4'h2;
    localparam logic [AluOpWidth-1:0] AluAnd  = 4'h3;
    localparam logic [AluOpWidth-1:0] AluOr   = 4'h4;
    localparam logic [AluOpWidth-1:0] AluSlt  = 4'h5;
    localparam logic [AluOpWidth-1:0] AluSll  = 4'h6;
    localparam logic [AluOpWidth-1:0] AluLui  = 4'h7;

    // write-back source override
    localparam logic [1:0] HiloNone = 2'd0;
    localparam logic [1:0] HiloHi   = 2'd1;
    localparam logic [1:0] HiloLo   = 2'd2;

    // one restoring step per quotient bit
    localparam int DivCycles = 32;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

endpackage

`default_nettype wire
